// ==== hdl/icache_pkg.sv ====
package icache_pkg;

    //////////////////////////////////////////////////
    // address and word geometry
    //////////////////////////////////////////////////

    // fetch address bits
    localparam int ADDR_WIDTH = 32;
    // instruction word bits
    localparam int WORD_WIDTH = 32;
    // byte within word
    localparam int OFFSET_WIDTH = 2;

    //////////////////////////////////////////////////
    // line and set geometry
    //////////////////////////////////////////////////

    // word within line
    localparam int WORD_SEL_WIDTH = 2;
    // words per line, one refill beat each
    localparam int LINE_WORDS = 1 << WORD_SEL_WIDTH;
    // 16 sets unless the top level overrides
    localparam int INDEX_WIDTH_DEFAULT = 4;
    // two ways, one lru bit per set
    localparam int WAYS = 2;

endpackage

// ==== hdl/icache_bram.sv ====
module icache_bram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    // write port
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic                  we,
    // read port, one cycle latency
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0] dout
);

    // storage, no reset
    logic [DATA_WIDTH-1:0] mem [1 << ADDR_WIDTH];

    // write and registered read share the edge
    // same-address read sees the old word
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        dout <= mem[raddr];
    end

endmodule

// ==== hdl/icache_tagv.sv ====
module icache_tagv import icache_pkg::*; #(
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEFAULT
) (
    input  logic                   clk,
    input  logic                   arst_n,
    // lookup side
    input  logic [INDEX_WIDTH-1:0] rd_index,
    input  logic [ADDR_WIDTH-INDEX_WIDTH-WORD_SEL_WIDTH-OFFSET_WIDTH-1:0] cmp_tag,
    // refill side
    input  logic [INDEX_WIDTH-1:0] wr_index,
    input  logic [ADDR_WIDTH-INDEX_WIDTH-WORD_SEL_WIDTH-OFFSET_WIDTH-1:0] wr_tag,
    input  logic [WAYS-1:0]        we,
    input  logic                   flush,
    // per-way match, one cycle after the lookup
    output logic [WAYS-1:0]        hit
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;
    localparam int SETS = 1 << INDEX_WIDTH;

    //////////////////////////////////////////////////
    // lookup stage
    //////////////////////////////////////////////////

    // held beside the tag memory read
    logic [INDEX_WIDTH-1:0] rd_index_q;
    logic [TAG_WIDTH-1:0]   cmp_tag_q;

    always_ff @(posedge clk) begin
        rd_index_q <= rd_index;
        cmp_tag_q  <= cmp_tag;
    end

    //////////////////////////////////////////////////
    // ways
    //////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [TAG_WIDTH-1:0] tag_q;
        logic [SETS-1:0]      valid;

        icache_bram #(
            .DATA_WIDTH(TAG_WIDTH),
            .ADDR_WIDTH(INDEX_WIDTH)
        ) u_tag (
            .clk  (clk),
            .waddr(wr_index),
            .din  (wr_tag),
            .we   (we[w]),
            .raddr(rd_index),
            .dout (tag_q)
        );

        // flush clears the whole way
        // refill sets one set
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                valid <= '0;
            end else if (flush) begin
                valid <= '0;
            end else if (we[w]) begin
                valid[wr_index] <= 1'b1;
            end
        end

        // valid taken at the read index of this lookup
        assign hit[w] = valid[rd_index_q] & (tag_q == cmp_tag_q);
    end

endmodule

// ==== hdl/icache_data.sv ====
module icache_data import icache_pkg::*; #(
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEFAULT
) (
    input  logic                      clk,
    // read side
    input  logic [INDEX_WIDTH-1:0]    rd_index,
    input  logic [WORD_SEL_WIDTH-1:0] rd_word,
    // refill side, one word per beat
    input  logic [INDEX_WIDTH-1:0]    wr_index,
    input  logic [WORD_SEL_WIDTH-1:0] wr_word,
    input  logic [WORD_WIDTH-1:0]     wr_data,
    input  logic [WAYS-1:0]           we,
    // both ways, selected in ctrl
    output logic [WORD_WIDTH-1:0]     rd_data_way0,
    output logic [WORD_WIDTH-1:0]     rd_data_way1
);

    // word address is set then word
    localparam int WADDR_WIDTH = INDEX_WIDTH + WORD_SEL_WIDTH;

    logic [WORD_WIDTH-1:0] rd_data [WAYS];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_bram #(
            .DATA_WIDTH(WORD_WIDTH),
            .ADDR_WIDTH(WADDR_WIDTH)
        ) u_data (
            .clk  (clk),
            .waddr({wr_index, wr_word}),
            .din  (wr_data),
            .we   (we[w]),
            .raddr({rd_index, rd_word}),
            .dout (rd_data[w])
        );
    end

    assign rd_data_way0 = rd_data[0];
    assign rd_data_way1 = rd_data[1];

endmodule

// ==== hdl/icache_ctrl.sv ====
module icache_ctrl import icache_pkg::*; #(
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEFAULT
) (
    input  logic                      clk,
    input  logic                      arst_n,
    // fetch port
    input  logic                      fetch_req,
    input  logic [ADDR_WIDTH-1:0]     fetch_addr,
    output logic                      busy,
    output logic                      rsp_valid,
    output logic [WORD_WIDTH-1:0]     rsp_data,
    input  logic                      flush,
    // memory port
    output logic                      mem_req,
    output logic [ADDR_WIDTH-1:0]     mem_addr,
    input  logic                      mem_rvalid,
    input  logic [WORD_WIDTH-1:0]     mem_rdata,
    // tag array
    output logic [INDEX_WIDTH-1:0]    tag_rd_index,
    output logic [ADDR_WIDTH-INDEX_WIDTH-WORD_SEL_WIDTH-OFFSET_WIDTH-1:0] tag_cmp_tag,
    output logic [WAYS-1:0]           tag_we,
    output logic [INDEX_WIDTH-1:0]    tag_wr_index,
    output logic [ADDR_WIDTH-INDEX_WIDTH-WORD_SEL_WIDTH-OFFSET_WIDTH-1:0] tag_wr_tag,
    output logic                      tag_flush,
    input  logic [WAYS-1:0]           hit,
    // data array
    output logic [INDEX_WIDTH-1:0]    data_rd_index,
    output logic [WORD_SEL_WIDTH-1:0] data_rd_word,
    output logic [WAYS-1:0]           data_we,
    output logic [INDEX_WIDTH-1:0]    data_wr_index,
    output logic [WORD_SEL_WIDTH-1:0] data_wr_word,
    output logic [WORD_WIDTH-1:0]     data_wr_data,
    input  logic [WORD_WIDTH-1:0]     rd_data_way0,
    input  logic [WORD_WIDTH-1:0]     rd_data_way1
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;
    localparam int SETS = 1 << INDEX_WIDTH;
    localparam int LINE_LSB = WORD_SEL_WIDTH + OFFSET_WIDTH;
    localparam int TAG_LSB = LINE_LSB + INDEX_WIDTH;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_REFILL = 2'd1;
    localparam logic [1:0] S_REREAD = 2'd2;

    logic [1:0]                         state;
    logic [ADDR_WIDTH-1:OFFSET_WIDTH]   lk_addr;
    logic                               lk_valid;
    logic [WORD_SEL_WIDTH-1:0]          beat_cnt;
    logic                               reread_chk;
    logic                               victim_q;
    // lru bit names the way to replace
    logic [SETS-1:0]                    lru;

    logic [INDEX_WIDTH-1:0] lk_index;
    logic [TAG_WIDTH-1:0]   lk_tag;
    logic                   miss, beat, last_beat, vict_way, rsp_fire, rsp_way;
    logic [WAYS-1:0]        vict_onehot;

    assign lk_tag   = lk_addr[ADDR_WIDTH-1:TAG_LSB];
    assign lk_index = lk_addr[TAG_LSB-1:LINE_LSB];

    //////////////////////////////////////////////////
    // lookup stage
    //////////////////////////////////////////////////

    // only ever set in idle
    assign miss = lk_valid & ~(|hit);
    assign busy = (state != S_IDLE) | miss;

    // reread walks the held address, otherwise the incoming fetch
    assign tag_rd_index  = (state == S_REREAD) ? lk_index : fetch_addr[TAG_LSB-1:LINE_LSB];
    assign tag_cmp_tag   = (state == S_REREAD) ? lk_tag : fetch_addr[ADDR_WIDTH-1:TAG_LSB];
    assign data_rd_index = tag_rd_index;
    assign data_rd_word  = (state == S_REREAD) ? lk_addr[LINE_LSB-1:OFFSET_WIDTH]
                                               : fetch_addr[LINE_LSB-1:OFFSET_WIDTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lk_valid <= 1'b0;
        end else begin
            lk_valid <= fetch_req & ~busy;
        end
    end

    // address held through the whole miss
    always_ff @(posedge clk) begin
        if (fetch_req && !busy) begin
            lk_addr <= fetch_addr[ADDR_WIDTH-1:OFFSET_WIDTH];
        end
    end

    //////////////////////////////////////////////////
    // refill
    //////////////////////////////////////////////////

    // request rises with the miss itself
    assign mem_req   = (state == S_REFILL) | miss;
    assign mem_addr  = {lk_addr[ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};
    assign beat      = mem_req & mem_rvalid;
    assign last_beat = beat & (beat_cnt == WORD_SEL_WIDTH'(LINE_WORDS - 1));

    // lru cleared on flush, so it names an empty way whenever one exists
    assign vict_way    = (state == S_REFILL) ? victim_q : lru[lk_index];
    assign vict_onehot = WAYS'(1) << vict_way;

    assign data_we       = beat ? vict_onehot : '0;
    assign data_wr_index = lk_index;
    assign data_wr_word  = beat_cnt;
    assign data_wr_data  = mem_rdata;
    // tag and valid go in with the last word
    assign tag_we        = last_beat ? vict_onehot : '0;
    assign tag_wr_index  = lk_index;
    assign tag_wr_tag    = lk_tag;
    assign tag_flush     = flush & ~busy;

    // wraps back to 0 after the last beat
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_cnt <= '0;
        end else if (beat) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            victim_q   <= 1'b0;
            reread_chk <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        state    <= S_REFILL;
                        victim_q <= lru[lk_index];
                    end
                end
                S_REFILL: begin
                    if (last_beat) begin
                        state <= S_REREAD;
                    end
                end
                // first cycle reads, second returns the word
                S_REREAD: begin
                    reread_chk <= ~reread_chk;
                    if (reread_chk) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // response and lru
    //////////////////////////////////////////////////

    assign rsp_fire = (lk_valid & (|hit)) | ((state == S_REREAD) & reread_chk);
    assign rsp_way  = (state == S_REREAD) ? victim_q : hit[1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid <= 1'b0;
            lru       <= '0;
        end else begin
            rsp_valid <= rsp_fire;
            if (tag_flush) begin
                lru <= '0;
            end else if (rsp_fire) begin
                // point away from the way just used
                lru[lk_index] <= ~rsp_way;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            rsp_data <= rsp_way ? rd_data_way1 : rd_data_way0;
        end
    end

endmodule

// ==== hdl/icache_top.sv ====
module icache_top import icache_pkg::*; #(
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEFAULT
) (
    input  logic                  clk,
    input  logic                  arst_n,
    // fetch port
    input  logic                  fetch_req,
    input  logic [ADDR_WIDTH-1:0] fetch_addr,
    output logic                  busy,
    output logic                  rsp_valid,
    output logic [WORD_WIDTH-1:0] rsp_data,
    input  logic                  flush,
    // refill port
    output logic                  mem_req,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    input  logic                  mem_rvalid,
    input  logic [WORD_WIDTH-1:0] mem_rdata
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;

    // ctrl to tag array
    logic [INDEX_WIDTH-1:0]    tag_rd_index, tag_wr_index;
    logic [TAG_WIDTH-1:0]      tag_cmp_tag, tag_wr_tag;
    logic [WAYS-1:0]           tag_we, hit;
    logic                      tag_flush;
    // ctrl to data array
    logic [INDEX_WIDTH-1:0]    data_rd_index, data_wr_index;
    logic [WORD_SEL_WIDTH-1:0] data_rd_word, data_wr_word;
    logic [WAYS-1:0]           data_we;
    logic [WORD_WIDTH-1:0]     data_wr_data, rd_data_way0, rd_data_way1;

    icache_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .busy         (busy),
        .rsp_valid    (rsp_valid),
        .rsp_data     (rsp_data),
        .flush        (flush),
        .mem_req      (mem_req),
        .mem_addr     (mem_addr),
        .mem_rvalid   (mem_rvalid),
        .mem_rdata    (mem_rdata),
        .tag_rd_index (tag_rd_index),
        .tag_cmp_tag  (tag_cmp_tag),
        .tag_we       (tag_we),
        .tag_wr_index (tag_wr_index),
        .tag_wr_tag   (tag_wr_tag),
        .tag_flush    (tag_flush),
        .hit          (hit),
        .data_rd_index(data_rd_index),
        .data_rd_word (data_rd_word),
        .data_we      (data_we),
        .data_wr_index(data_wr_index),
        .data_wr_word (data_wr_word),
        .data_wr_data (data_wr_data),
        .rd_data_way0 (rd_data_way0),
        .rd_data_way1 (rd_data_way1)
    );

    icache_tagv #(.INDEX_WIDTH(INDEX_WIDTH)) u_tagv (
        .clk     (clk),
        .arst_n  (arst_n),
        .rd_index(tag_rd_index),
        .cmp_tag (tag_cmp_tag),
        .wr_index(tag_wr_index),
        .wr_tag  (tag_wr_tag),
        .we      (tag_we),
        .flush   (tag_flush),
        .hit     (hit)
    );

    icache_data #(.INDEX_WIDTH(INDEX_WIDTH)) u_data (
        .clk         (clk),
        .rd_index    (data_rd_index),
        .rd_word     (data_rd_word),
        .wr_index    (data_wr_index),
        .wr_word     (data_wr_word),
        .wr_data     (data_wr_data),
        .we          (data_we),
        .rd_data_way0(rd_data_way0),
        .rd_data_way1(rd_data_way1)
    );

endmodule

// ==== test/icache_props.sv ====
module icache_props import icache_pkg::*; #(
    parameter int INDEX_WIDTH = INDEX_WIDTH_DEFAULT
) (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  fetch_req,
    input logic [ADDR_WIDTH-1:0] fetch_addr,
    input logic                  busy,
    input logic                  rsp_valid,
    input logic [WORD_WIDTH-1:0] rsp_data,
    input logic                  flush,
    input logic                  mem_req,
    input logic [ADDR_WIDTH-1:0] mem_addr
);

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - WORD_SEL_WIDTH - OFFSET_WIDTH;
    localparam int SETS = 1 << INDEX_WIDTH;
    localparam int LINE_LSB = WORD_SEL_WIDTH + OFFSET_WIDTH;
    localparam int TAG_LSB = LINE_LSB + INDEX_WIDTH;
    // memory model contents are the byte address xor this
    localparam logic [WORD_WIDTH-1:0] MEM_PATTERN = 32'ha5a5_0000;

    // first failure, read by the testbench
    logic                  err;
    string                 err_sig;
    logic [WORD_WIDTH-1:0] err_exp;
    logic [WORD_WIDTH-1:0] err_act;

    initial err = 1'b0;

    task automatic record_error(input string name, input logic [WORD_WIDTH-1:0] exp,
                                input logic [WORD_WIDTH-1:0] act);
        err_sig = name;
        err_exp = exp;
        err_act = act;
        err     = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // shadow tag, valid and lru model
    //////////////////////////////////////////////////

    logic [SETS-1:0]      sh_valid [WAYS];
    logic [TAG_WIDTH-1:0] sh_tag [WAYS][SETS];
    // names the way to replace
    logic [SETS-1:0]      sh_lru;

    logic                   accept;
    logic [INDEX_WIDTH-1:0] f_index;
    logic [TAG_WIDTH-1:0]   f_tag;
    logic [WAYS-1:0]        way_match;
    logic                   pred_hit;
    logic                   pred_victim;

    assign accept  = fetch_req & ~busy;
    assign f_index = fetch_addr[TAG_LSB-1:LINE_LSB];
    assign f_tag   = fetch_addr[ADDR_WIDTH-1:TAG_LSB];

    for (genvar w = 0; w < WAYS; w++) begin : g_match
        assign way_match[w] = sh_valid[w][f_index] & (sh_tag[w][f_index] == f_tag);
    end

    assign pred_hit = |way_match;
    // empty way first, way 0 before way 1, else lru
    assign pred_victim = !sh_valid[0][f_index] ? 1'b0 :
                         !sh_valid[1][f_index] ? 1'b1 : sh_lru[f_index];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < WAYS; w++) begin
                sh_valid[w] <= '0;
            end
            sh_lru <= '0;
        end else if (flush && !busy) begin
            for (int w = 0; w < WAYS; w++) begin
                sh_valid[w] <= '0;
            end
            sh_lru <= '0;
        end else if (accept) begin
            if (pred_hit) begin
                sh_lru[f_index] <= ~way_match[1];
            end else begin
                sh_valid[pred_victim][f_index] <= 1'b1;
                sh_lru[f_index]                <= ~pred_victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !pred_hit && !flush) begin
            sh_tag[pred_victim][f_index] <= f_tag;
        end
    end

    //////////////////////////////////////////////////
    // expected responses, in fetch order
    //////////////////////////////////////////////////

    logic [WORD_WIDTH-1:0] pend_data [4];
    logic [1:0]            pend_wr;
    logic [1:0]            pend_rd;
    logic [2:0]            pend_cnt;
    logic [WORD_WIDTH-1:0] exp_data;
    logic [ADDR_WIDTH-1:0] exp_line;
    // hit pipeline, one and two edges after the fetch
    logic                  hit_due1;
    logic                  hit_due2;
    logic                  miss_due;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_wr  <= '0;
            pend_rd  <= '0;
            pend_cnt <= '0;
            exp_line <= '0;
            hit_due1 <= 1'b0;
            hit_due2 <= 1'b0;
            miss_due <= 1'b0;
        end else begin
            hit_due1 <= accept & pred_hit;
            hit_due2 <= hit_due1;
            miss_due <= accept & ~pred_hit;
            if (accept) begin
                exp_line <= {fetch_addr[ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};
                pend_wr  <= pend_wr + 1'b1;
            end
            if (rsp_valid) begin
                pend_rd <= pend_rd + 1'b1;
            end
            pend_cnt <= pend_cnt + {2'b00, accept} - {2'b00, rsp_valid};
        end
    end

    // word aligned address xor the fill pattern
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_data[pend_wr] <= {fetch_addr[ADDR_WIDTH-1:OFFSET_WIDTH],
                                   {OFFSET_WIDTH{1'b0}}} ^ MEM_PATTERN;
        end
    end

    assign exp_data = pend_data[pend_rd];

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // outputs quiet while reset is held
    a_reset_idle: assert property (@(posedge clk)
        !arst_n |-> !busy && !rsp_valid && !mem_req)
    else begin
        record_error("{busy,rsp_valid,mem_req}", '0,
                     {$sampled(busy), $sampled(rsp_valid), $sampled(mem_req)});
        $error("output active during reset");
    end

    a_rsp_data: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> rsp_data == exp_data)
    else begin
        record_error("rsp_data", $sampled(exp_data), $sampled(rsp_data));
        $error("rsp_data differs from the memory word");
    end

    // no response without an open fetch
    a_rsp_owed: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> pend_cnt != 0)
    else begin
        record_error("rsp_valid", '0, $sampled(rsp_valid));
        $error("response with no fetch outstanding");
    end

    a_hit_timing: assert property (@(posedge clk) disable iff (!arst_n)
        hit_due2 |-> rsp_valid)
    else begin
        record_error("rsp_valid", 1, $sampled(rsp_valid));
        $error("predicted hit gave no response one cycle later");
    end

    a_hit_no_mem: assert property (@(posedge clk) disable iff (!arst_n)
        hit_due1 |-> !mem_req)
    else begin
        record_error("mem_req", '0, $sampled(mem_req));
        $error("predicted hit went to memory");
    end

    // miss goes out for the aligned line
    a_miss_req: assert property (@(posedge clk) disable iff (!arst_n)
        miss_due |-> mem_req && mem_addr == exp_line)
    else begin
        record_error("mem_addr", $sampled(exp_line),
                     $sampled(mem_req) ? $sampled(mem_addr) : 'x);
        $error("predicted miss without a matching memory request");
    end

    a_fetch_idle: assert property (@(posedge clk) disable iff (!arst_n)
        fetch_req |-> !busy)
    else begin
        record_error("busy", '0, $sampled(busy));
        $error("fetch raised while the cache was busy");
    end

endmodule

// ==== test/icache_tb.sv ====
module icache_tb import icache_pkg::*; ();

    localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH_DEFAULT - WORD_SEL_WIDTH - OFFSET_WIDTH;
    localparam logic [WORD_WIDTH-1:0] MEM_PATTERN = 32'ha5a5_0000;
    localparam int SEED = 32'h62e2;
    // cycles any single wait may take
    localparam int TIMEOUT = 100;

    localparam logic [TAG_WIDTH-1:0] TAG_A = 24'h000010;
    localparam logic [TAG_WIDTH-1:0] TAG_B = 24'h000abc;
    localparam logic [TAG_WIDTH-1:0] TAG_C = 24'h0123ff;

    logic                  clk;
    logic                  arst_n;
    logic                  fetch_req;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic                  busy;
    logic                  rsp_valid;
    logic [WORD_WIDTH-1:0] rsp_data;
    logic                  flush;
    logic                  mem_req;
    logic [ADDR_WIDTH-1:0] mem_addr;
    logic                  mem_rvalid;
    logic [WORD_WIDTH-1:0] mem_rdata;

    integer gap_seed;
    integer fetch_seed;
    int     issued;
    int     answered;
    logic [TAG_WIDTH-1:0] tag_pool [3];

    icache_top #(.INDEX_WIDTH(INDEX_WIDTH_DEFAULT)) dut0 (.*);

    bind icache_top icache_props #(.INDEX_WIDTH(INDEX_WIDTH)) u_props (
        .clk       (clk),
        .arst_n    (arst_n),
        .fetch_req (fetch_req),
        .fetch_addr(fetch_addr),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data),
        .flush     (flush),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr)
    );

    always #2 clk = ~clk;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
                                                        input int index, input int word);
        return {tag, INDEX_WIDTH_DEFAULT'(index), WORD_SEL_WIDTH'(word), OFFSET_WIDTH'(0)};
    endfunction

    // called on a falling edge, returns on one
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timeout: busy never fell");
            end
        end
    endtask

    task automatic wait_responses();
        int cycles;
        cycles = 0;
        while (answered != issued) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("timeout: rsp_valid missing for an accepted fetch");
            end
        end
    endtask

    task automatic issue_fetch(input logic [ADDR_WIDTH-1:0] addr);
        wait_idle();
        fetch_req  = 1'b1;
        fetch_addr = addr;
        issued++;
        @(negedge clk);
        fetch_req = 1'b0;
    endtask

    task automatic pulse_flush();
        wait_responses();
        wait_idle();
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // memory model
    //////////////////////////////////////////////////

    // four beats in word order, 0 to 3 idle cycles before each
    task automatic serve_refill();
        int                    gap;
        logic [ADDR_WIDTH-1:0] line;
        line = mem_addr;
        for (int b = 0; b < LINE_WORDS; b++) begin
            gap = $unsigned($random(gap_seed)) % 4;
            repeat (gap) @(negedge clk);
            mem_rvalid = 1'b1;
            mem_rdata  = (line + ADDR_WIDTH'(b * 4)) ^ MEM_PATTERN;
            @(negedge clk);
            mem_rvalid = 1'b0;
        end
    endtask

    always begin
        @(negedge clk);
        if (arst_n && mem_req) begin
            serve_refill();
        end
    end

    // responses counted on the rising edge
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            answered <= 0;
        end else if (rsp_valid) begin
            answered <= answered + 1;
        end
    end

    // first assertion failure ends the run
    always @(negedge clk) begin
        if (dut0.u_props.err) begin
            report_failure($sformatf("Fail %s expected 0x%h got 0x%h", dut0.u_props.err_sig,
                                     dut0.u_props.err_exp, dut0.u_props.err_act));
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        fetch_req   = 1'b0;
        fetch_addr  = '0;
        flush       = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        gap_seed    = SEED;
        fetch_seed  = SEED;
        issued      = 0;
        tag_pool[0] = TAG_A;
        tag_pool[1] = TAG_B;
        tag_pool[2] = TAG_C;

        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // cold miss, then the rest of the line back to back
        issue_fetch(make_addr(TAG_A, 1, 0));
        issue_fetch(make_addr(TAG_A, 1, 1));
        issue_fetch(make_addr(TAG_A, 1, 2));
        issue_fetch(make_addr(TAG_A, 1, 3));
        // second tag fills the other way
        issue_fetch(make_addr(TAG_B, 1, 2));
        issue_fetch(make_addr(TAG_A, 1, 3));
        issue_fetch(make_addr(TAG_B, 1, 0));
        // third tag evicts the older way, A here
        issue_fetch(make_addr(TAG_C, 1, 1));
        issue_fetch(make_addr(TAG_B, 1, 3));
        issue_fetch(make_addr(TAG_A, 1, 2));
        issue_fetch(make_addr(TAG_C, 1, 0));
        // second set stays apart
        issue_fetch(make_addr(TAG_C, 2, 3));
        issue_fetch(make_addr(TAG_C, 2, 0));

        // everything misses again after flush
        pulse_flush();
        issue_fetch(make_addr(TAG_A, 1, 2));
        issue_fetch(make_addr(TAG_C, 2, 1));
        issue_fetch(make_addr(TAG_B, 1, 0));

        // three tags over four sets
        for (int n = 0; n < 200; n++) begin
            issue_fetch(make_addr(tag_pool[$unsigned($random(fetch_seed)) % 3],
                                  $unsigned($random(fetch_seed)) % 4,
                                  $unsigned($random(fetch_seed)) % 4));
        end

        wait_responses();
        wait_idle();
        @(negedge clk);
        if (dut0.u_props.err) begin
            report_failure($sformatf("Fail %s expected 0x%h got 0x%h", dut0.u_props.err_sig,
                                     dut0.u_props.err_exp, dut0.u_props.err_act));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// ==== build.f ====
hdl/icache_pkg.sv
hdl/icache_bram.sv
hdl/icache_tagv.sv
hdl/icache_data.sv
hdl/icache_ctrl.sv
hdl/icache_top.sv
test/icache_props.sv
test/icache_tb.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - hdl/icache_pkg.sv
      - hdl/icache_bram.sv
      - hdl/icache_tagv.sv
      - hdl/icache_data.sv
      - hdl/icache_ctrl.sv
      - hdl/icache_top.sv
  - target: test
    files:
      - test/icache_props.sv
      - test/icache_tb.sv
